/* gpmc_settings.svh */
// build-time sizes for the GPMC ingress path
// FIFO depth must stay well above GPMC_MIN_SPACE16/2 lines or ready_o never rises
`ifndef GPMC_SETTINGS_SVH
`define GPMC_SETTINGS_SVH

// log2 of the line FIFO depth
// 9 gives 512 lines of 36 bits
`define GPMC_FIFO_AW 9

// free half-word slots required before the host may write
// compared as lines, so the real threshold is half of this
// the host must stop within 2 cycles of ready_o falling
`define GPMC_MIN_SPACE16 128

`endif

/* gpmc_pkg.sv */
// shared types for the GPMC ingress path
// line data is little-endian: the first half-word of a pair is in bits 15:0
package gpmc_pkg;

    // one host bus transfer
    typedef logic [15:0] word_t;

    // FIFO line, 36 bits, msb first
    // occ  - occupancy code, see OCC_* below
    // eop  - last line of a packet
    // sop  - line that carries the header word
    // data - two half-words, first one low
    typedef struct packed {
        logic [1:0]  occ;
        logic        eop;
        logic        sop;
        logic [31:0] data;
    } line_t;

    // both halves of the line are valid
    localparam logic [1:0] OCC_FULL = 2'd0;

    // only the low half is valid
    // seen only on the eop line of an odd-length packet
    localparam logic [1:0] OCC_HALF = 2'd2;

    // codes 1 and 3 are never produced

endpackage

/* frame_tracker.sv */
// follows packet framing from the header length, header counts itself
// a header of zero is illegal, the host must never send one
module frame_tracker (
    input  logic            gpif_clk,
    input  logic            rst_n_i,
    input  gpmc_pkg::word_t data_i,
    input  logic            valid_i,
    output logic            close_o,
    output logic            sop_o,
    output logic            eop_o,
    output logic            half_o
);

    // high inside a packet, low while waiting for a header
    logic        busy_q;
    // words still to come in this packet, the next one included
    logic [15:0] rem_q;
    // pair phase, 0 means the next word fills the low half
    logic        phase_q;
    // the line being filled holds the header
    logic        sop_q;

    // decode of the word on data_i in this cycle
    logic        hdr_now;
    logic        phase_now;
    logic        last_now;
    logic        close_now;
    logic        sop_now;

    always_comb begin
        hdr_now   = !busy_q;
        // every header restarts the pair phase
        phase_now = hdr_now ? 1'b0 : phase_q;
        last_now  = hdr_now ? (data_i == 16'd1) : (rem_q == 16'd1);
        // a line closes on the high half or on the last word
        close_now = phase_now || last_now;
        sop_now   = hdr_now || sop_q;
    end

    always_ff @(posedge gpif_clk) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            rem_q   <= '0;
            phase_q <= 1'b0;
            sop_q   <= 1'b0;
            close_o <= 1'b0;
            sop_o   <= 1'b0;
            eop_o   <= 1'b0;
            half_o  <= 1'b0;
        end else begin
            close_o <= valid_i && close_now;
            if (valid_i) begin
                busy_q  <= !last_now;
                // header loads the count of words that follow it
                rem_q   <= hdr_now ? (data_i - 16'd1) : (rem_q - 16'd1);
                phase_q <= !phase_now;
                sop_q   <= sop_now && !close_now;
                if (close_now) begin
                    sop_o  <= sop_now;
                    eop_o  <= last_now;
                    // last word landed in the low half
                    half_o <= last_now && !phase_now;
                end
            end
        end
    end

    // a zero-length header would wrap the word count
    a_no_zero_header: assert property (@(posedge gpif_clk) disable iff (!rst_n_i)
        (valid_i && hdr_now) |-> (data_i != 16'd0));

    // a close right after another one can only be a lone tail word
    a_close_spacing: assert property (@(posedge gpif_clk) disable iff (!rst_n_i)
        (close_o && $past(close_o)) |-> (half_o && eop_o));

endmodule

/* half_word_stage.sv */
// two-deep shift of accepted half-words, no framing knowledge
// contents are only meaningful on the cycle after a tracker close
module half_word_stage (
    input  logic            gpif_clk,
    input  logic            rst_n_i,
    input  gpmc_pkg::word_t data_i,
    input  logic            valid_i,
    output gpmc_pkg::word_t last_o,
    output gpmc_pkg::word_t prev_o
);

    // newest accepted word
    gpmc_pkg::word_t last_q;
    // the word accepted before it
    gpmc_pkg::word_t prev_q;

    always_ff @(posedge gpif_clk) begin
        if (!rst_n_i) begin
            last_q <= '0;
            prev_q <= '0;
        end else if (valid_i) begin
            // shift on every accepted word, gaps hold the pair
            prev_q <= last_q;
            last_q <= data_i;
        end
    end

    // runs beside the tracker on the same accepting edge
    // so the packer sees the pair and the close decision together
    assign last_o = last_q;
    assign prev_o = prev_q;

endmodule

/* line_packer.sv */
// builds one registered FIFO line per tracker close
// acts one edge after the close, so the stage pair is still intact
module line_packer (
    input  logic            gpif_clk,
    input  logic            rst_n_i,
    input  logic            close_i,
    input  logic            sop_i,
    input  logic            eop_i,
    input  logic            half_i,
    input  gpmc_pkg::word_t last_i,
    input  gpmc_pkg::word_t prev_i,
    output gpmc_pkg::line_t wr_line_o,
    output logic            wr_en_o,
    output logic            pending_o
);

    gpmc_pkg::line_t line_next;

    always_comb begin
        line_next.sop = sop_i;
        line_next.eop = eop_i;
        if (half_i) begin
            // odd packet tail, lone word goes low
            line_next.occ  = gpmc_pkg::OCC_HALF;
            line_next.data = {16'h0000, last_i};
        end else begin
            // little-endian pair, older word in the low half
            line_next.occ  = gpmc_pkg::OCC_FULL;
            line_next.data = {last_i, prev_i};
        end
    end

    always_ff @(posedge gpif_clk) begin
        if (!rst_n_i) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= close_i;
        end
    end

    // payload only
    always_ff @(posedge gpif_clk) begin
        if (close_i) begin
            wr_line_o <= line_next;
        end
    end

    // a line decided or built but not yet in the FIFO
    // lets the FIFO count it as used space
    assign pending_o = close_i || wr_en_o;

    // a half line only ever ends a packet
    a_half_is_eop: assert property (@(posedge gpif_clk) disable iff (!rst_n_i)
        half_i |-> eop_i);

endmodule

/* line_fifo.sv */
// synchronous FWFT line buffer with a registered head and input space level
// the host is not stalled, a write into a full memory is a protocol error
`include "gpmc_settings.svh"

module line_fifo (
    input  logic            gpif_clk,
    input  logic            rst_n_i,
    input  gpmc_pkg::line_t wr_line_i,
    input  logic            wr_en_i,
    input  logic            pending_i,
    output gpmc_pkg::line_t out_line_o,
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output logic            ready_o
);

    localparam int AW    = `GPMC_FIFO_AW;
    localparam int CW    = AW + 2;
    localparam int DEPTH = 1 << AW;
    // most lines that may be held while the host can still write
    localparam logic [CW-1:0] USED_MAX = CW'(DEPTH - `GPMC_MIN_SPACE16 / 2);

    gpmc_pkg::line_t mem [0:DEPTH-1];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // lines in memory, head register not included
    logic [AW:0]   mem_cnt;

    logic          pop;
    logic          mem_empty;
    logic          mem_full;
    logic          head_free;
    logic          bypass;
    logic          mem_wr;
    logic          mem_rd;
    logic [CW-1:0] used;

    always_comb begin
        pop       = out_valid_o && out_ready_i;
        mem_empty = (mem_cnt == '0);
        mem_full  = (mem_cnt == (AW+1)'(DEPTH));
        // head can take a new line this edge
        head_free = !out_valid_o || pop;
        // empty FIFO, write lands straight in the head
        bypass    = wr_en_i && mem_empty && head_free;
        mem_wr    = wr_en_i && !bypass;
        mem_rd    = head_free && !mem_empty;
        // memory plus head plus lines still in the packer
        used      = CW'(mem_cnt) + CW'(out_valid_o) + CW'(pending_i);
    end

    always_ff @(posedge gpif_clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= wr_line_i;
        end
    end

    // head payload, refilled from memory first to keep order
    always_ff @(posedge gpif_clk) begin
        if (mem_rd) begin
            out_line_o <= mem[rd_ptr];
        end else if (bypass) begin
            out_line_o <= wr_line_i;
        end
    end

    always_ff @(posedge gpif_clk) begin
        if (!rst_n_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            mem_cnt     <= '0;
            out_valid_o <= 1'b0;
            ready_o     <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({mem_wr, mem_rd})
                2'b10:   mem_cnt <= mem_cnt + 1'b1;
                2'b01:   mem_cnt <= mem_cnt - 1'b1;
                default: mem_cnt <= mem_cnt;
            endcase
            if (head_free) begin
                out_valid_o <= mem_rd || bypass;
            end
            // level for the host, updated every cycle
            ready_o <= (used <= USED_MAX);
        end
    end

    // ready_o margin must keep the host off a full memory
    a_no_overflow: assert property (@(posedge gpif_clk) disable iff (!rst_n_i)
        wr_en_i |-> !mem_full);

    // a line waiting in memory always has a valid head in front of it
    a_head_filled: assert property (@(posedge gpif_clk) disable iff (!rst_n_i)
        !mem_empty |-> out_valid_o);

endmodule

/* gpmc16_to_line_top.sv */
// GPMC 16-bit ingress to 36-bit lines, single clock
// host writes only while ready_o is high and must stop within 2 cycles of it falling
module gpmc16_to_line_top (
    input  logic            gpif_clk,
    input  logic            rst_n_i,
    input  gpmc_pkg::word_t data_i,
    input  logic            valid_i,
    output logic            ready_o,
    output gpmc_pkg::line_t out_line_o,
    output logic            out_valid_o,
    input  logic            out_ready_i
);

    // tracker to packer
    logic            close;
    logic            sop;
    logic            eop;
    logic            half;
    // stage to packer
    gpmc_pkg::word_t last_word;
    gpmc_pkg::word_t prev_word;
    // packer to FIFO
    gpmc_pkg::line_t wr_line;
    logic            wr_en;
    logic            pending;

    // framing and data run side by side on the same input word
    frame_tracker frame_tracker_i (
        .gpif_clk (gpif_clk),
        .rst_n_i  (rst_n_i),
        .data_i   (data_i),
        .valid_i  (valid_i),
        .close_o  (close),
        .sop_o    (sop),
        .eop_o    (eop),
        .half_o   (half)
    );

    half_word_stage half_word_stage_i (
        .gpif_clk (gpif_clk),
        .rst_n_i  (rst_n_i),
        .data_i   (data_i),
        .valid_i  (valid_i),
        .last_o   (last_word),
        .prev_o   (prev_word)
    );

    line_packer line_packer_i (
        .gpif_clk  (gpif_clk),
        .rst_n_i   (rst_n_i),
        .close_i   (close),
        .sop_i     (sop),
        .eop_i     (eop),
        .half_i    (half),
        .last_i    (last_word),
        .prev_i    (prev_word),
        .wr_line_o (wr_line),
        .wr_en_o   (wr_en),
        .pending_o (pending)
    );

    line_fifo line_fifo_i (
        .gpif_clk    (gpif_clk),
        .rst_n_i     (rst_n_i),
        .wr_line_i   (wr_line),
        .wr_en_i     (wr_en),
        .pending_i   (pending),
        .out_line_o  (out_line_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .ready_o     (ready_o)
    );

endmodule

/* gpmc_tb.sv */
// self-checking testbench for gpmc16_to_line_top, random packets from a fixed seed
// every failure is fatal, expected lines are built from the packet framing rules
`include "gpmc_settings.svh"

module gpmc_tb;

    localparam int DEPTH    = 1 << `GPMC_FIFO_AW;
    localparam int USED_MAX = DEPTH - `GPMC_MIN_SPACE16 / 2;
    // packet counts per test group
    localparam int N_SINGLE = 6;
    localparam int N_B2B    = 12;
    localparam int N_RAND   = 40;
    localparam int N_SPACE  = 36;
    localparam int N_PKT    = N_SINGLE + N_B2B + N_RAND + N_SPACE;

    logic            gpif_clk;
    logic            rst_n_i;
    gpmc_pkg::word_t data_i;
    logic            valid_i;
    logic            ready_o;
    gpmc_pkg::line_t out_line_o;
    logic            out_valid_o;
    logic            out_ready_i;

    integer          seed = 42049;
    int              plen [0:N_PKT-1];
    int              limit = 1000000;
    int              cycles = 0;
    // lines closed by words handed to the DUT
    int              lines_in = 0;
    // 0 always ready, 1 random, 2 held low
    int              ready_mode = 0;
    logic            next_ready = 1'b1;
    string           test_name = "reset";
    gpmc_pkg::line_t exp_q [$];

    gpmc16_to_line_top gpmc16_to_line_top_i (
        .gpif_clk    (gpif_clk),
        .rst_n_i     (rst_n_i),
        .data_i      (data_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .out_line_o  (out_line_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial gpif_clk = 1'b0;
    always #2 gpif_clk = ~gpif_clk;

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "first error reached, run stopped");
    endtask

    task automatic check_line(input string name, input gpmc_pkg::line_t exp,
                              input gpmc_pkg::line_t act);
        if (act !== exp) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s expected %b actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    // run limit from the packet lengths
    always @(posedge gpif_clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, lines still expected %0d", cycles, exp_q.size());
            stop_on_error();
        end
    end

    // output ready pattern picked on the falling edge, applied after the rising one
    always @(negedge gpif_clk) begin
        case (ready_mode)
            1:       next_ready = 1'($random(seed));
            2:       next_ready = 1'b0;
            default: next_ready = 1'b1;
        endcase
    end

    always @(posedge gpif_clk) begin
        #1;
        out_ready_i = next_ready;
    end

    // monitor, a transfer happens on the next rising edge
    always @(negedge gpif_clk) begin
        if (rst_n_i && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("unexpected line %h from the DUT while no line was expected", out_line_o);
                stop_on_error();
            end else begin
                check_line(test_name, exp_q.pop_front(), out_line_o);
            end
        end
    end

    // host model, one word per cycle and only while ready_o is seen high
    task automatic send_word(input gpmc_pkg::word_t w, input logic closes);
        while (!ready_o) begin
            @(posedge gpif_clk);
            #1;
        end
        data_i  = w;
        valid_i = 1'b1;
        if (closes) begin
            lines_in++;
        end
        @(posedge gpif_clk);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic send_packet(input int len, input int gap_max);
        gpmc_pkg::word_t pkt [0:39];
        gpmc_pkg::line_t ln;
        int              k;
        int              gap;
        // header carries the total length, itself included
        pkt[0] = 16'(len);
        for (k = 1; k < len; k++) begin
            pkt[k] = 16'($random(seed));
        end
        // pairs go low first, an odd tail sits alone in the low half
        for (k = 0; k < len; k += 2) begin
            ln.sop = (k == 0);
            ln.eop = (k + 2 >= len);
            if (k + 1 < len) begin
                ln.occ  = gpmc_pkg::OCC_FULL;
                ln.data = {pkt[k+1], pkt[k]};
            end else begin
                ln.occ  = gpmc_pkg::OCC_HALF;
                ln.data = {16'h0000, pkt[k]};
            end
            exp_q.push_back(ln);
        end
        for (k = 0; k < len; k++) begin
            send_word(pkt[k], (k % 2 == 1) || (k == len - 1));
            gap = (gap_max > 0) ? rand_range(0, gap_max) : 0;
            repeat (gap) begin
                @(posedge gpif_clk);
                #1;
            end
        end
    endtask

    task automatic set_ready_mode(input int m);
        ready_mode = m;
        @(posedge gpif_clk);
        #1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge gpif_clk);
            #1;
        end
        repeat (3) begin
            @(posedge gpif_clk);
            #1;
        end
        check_bit("drained_valid", 1'b0, out_valid_o);
    endtask

    initial begin
        int p;
        int total;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        data_i      = '0;
        out_ready_i = 1'b0;
        // lengths first so the run limit is known up front
        total = 0;
        for (p = 0; p < N_PKT; p++) begin
            if (p < N_SINGLE) begin
                plen[p] = (p < 5) ? p + 1 : 40;
            end else if (p < N_SINGLE + N_B2B + N_RAND) begin
                plen[p] = rand_range(1, 40);
            end else begin
                // long packets so the FIFO passes the space threshold
                plen[p] = rand_range(30, 40);
            end
            total += plen[p];
        end
        limit = total * 4 + 2000;

        repeat (2) @(posedge gpif_clk);
        #1;
        check_bit("reset_valid", 1'b0, out_valid_o);
        rst_n_i = 1'b1;
        @(posedge gpif_clk);
        #1;
        check_bit("reset_valid_after", 1'b0, out_valid_o);
        if (!ready_o) begin
            @(posedge gpif_clk);
            #1;
        end
        check_bit("reset_ready", 1'b1, ready_o);

        test_name = "single_packets";
        for (p = 0; p < N_SINGLE; p++) begin
            send_packet(plen[p], 0);
            wait_drain();
        end

        // no gaps, the pair phase must restart at each header
        test_name = "back_to_back";
        for (p = N_SINGLE; p < N_SINGLE + N_B2B; p++) begin
            send_packet(plen[p], 0);
        end
        wait_drain();

        test_name = "random_backpressure";
        set_ready_mode(1);
        for (p = N_SINGLE + N_B2B; p < N_SINGLE + N_B2B + N_RAND; p++) begin
            send_packet(plen[p], 2);
        end
        wait_drain();

        test_name = "space_threshold";
        set_ready_mode(2);
        lines_in = 0;
        fork
            begin
                for (p = N_PKT - N_SPACE; p < N_PKT; p++) begin
                    send_packet(plen[p], 0);
                end
            end
            begin
                // output held, ready_o has to drop before the memory fills
                while (ready_o) begin
                    @(negedge gpif_clk);
                end
                check_bit("ready_fall_level", 1'b1, lines_in >= USED_MAX);
                repeat (10) @(negedge gpif_clk);
                check_bit("space_margin", 1'b1, lines_in < DEPTH);
                check_bit("ready_held_low", 1'b0, ready_o);
                check_bit("head_held", 1'b1, out_valid_o);
                @(posedge gpif_clk);
                #1;
                ready_mode = 0;
            end
        join
        wait_drain();
        check_bit("ready_after_drain", 1'b1, ready_o);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
gpmc_pkg.sv
frame_tracker.sv
half_word_stage.sv
line_packer.sv
line_fifo.sv
gpmc16_to_line_top.sv
gpmc_tb.sv
